/* files.f */
+incdir+hw
hw/ctrl_pkg.sv
hw/id_stage.sv
hw/id_decode.sv
hw/ex_stage.sv
hw/operand_select.sv
hw/ctrl_top.sv
sim/ctrl_tb.sv

/* hw/ctrl_defines.svh */
`ifndef CTRL_DEFINES_SVH
`define CTRL_DEFINES_SVH

// datapath and address width
`define CTRL_INSN_W 32

// register file address width
`define CTRL_REG_AW 5

// major opcode field
`define CTRL_OPC_MSB 31
`define CTRL_OPC_LSB 26

// register fields of the instruction word
`define CTRL_RD_MSB 25
`define CTRL_RD_LSB 21
`define CTRL_RA_MSB 20
`define CTRL_RA_LSB 16
`define CTRL_RB_MSB 15
`define CTRL_RB_LSB 11

// second alu field
`define CTRL_ALUOP2_W   4
`define CTRL_ALUOP2_MSB 9
`define CTRL_ALUOP2_LSB 6

// compare code sits in the rd field
`define CTRL_COMP_W 4

// nop opcode with bit 16 set marks a void slot
`define CTRL_VOID_BIT 16
`define CTRL_NOP_INSN 32'h1541_0000

// r9 takes the return address
`define CTRL_LINK_REG 5'd9

`endif

/* hw/ctrl_pkg.sv */
`include "ctrl_defines.svh"

package ctrl_pkg;

	// major opcodes of the kept instruction set
	typedef enum logic [`CTRL_OPC_MSB-`CTRL_OPC_LSB:0] {
		OPC_J = 6'h00, OPC_JAL = 6'h01, OPC_BNF = 6'h03, OPC_BF = 6'h04,
		OPC_NOP = 6'h05, OPC_MOVHI = 6'h06, OPC_XSYNC = 6'h08, OPC_RFE = 6'h09,
		OPC_JR = 6'h11, OPC_JALR = 6'h12,
		OPC_LWZ = 6'h21, OPC_LWS = 6'h22, OPC_LBZ = 6'h23, OPC_LBS = 6'h24,
		OPC_LHZ = 6'h25, OPC_LHS = 6'h26,
		OPC_ADDI = 6'h27, OPC_ADDIC = 6'h28, OPC_ANDI = 6'h29, OPC_ORI = 6'h2a,
		OPC_XORI = 6'h2b, OPC_MULI = 6'h2c, OPC_MFSPR = 6'h2d, OPC_SH_ROTI = 6'h2e,
		OPC_SFXXI = 6'h2f, OPC_MTSPR = 6'h30,
		OPC_SW = 6'h35, OPC_SB = 6'h36, OPC_SH = 6'h37,
		OPC_ALU = 6'h38, OPC_SFXX = 6'h39
	} opcode_e;

	typedef enum logic [2:0] {
		BR_NOP = 3'd0, BR_J = 3'd1, BR_JR = 3'd2,
		BR_BF = 3'd4, BR_BNF = 3'd5, BR_RFE = 3'd6
	} branch_op_e;

	// alu sub-ops keep their instruction encoding, nop is out of that range
	typedef enum logic [4:0] {
		ALU_ADD = 5'd0, ALU_ADDC = 5'd1, ALU_SUB = 5'd2, ALU_AND = 5'd3,
		ALU_OR = 5'd4, ALU_XOR = 5'd5, ALU_MUL = 5'd6, ALU_SHROT = 5'd8,
		ALU_DIV = 5'd9, ALU_DIVU = 5'd10, ALU_MULU = 5'd11, ALU_EXTHB = 5'd12,
		ALU_EXTW = 5'd13, ALU_FFL1 = 5'd15, ALU_MOVHI = 5'd16, ALU_COMP = 5'd17,
		ALU_NOP = 5'd31
	} alu_op_e;

	typedef enum logic [3:0] {
		LSU_NOP = 4'b0000,
		LSU_LBZ = 4'b0010, LSU_LBS = 4'b0011, LSU_LHZ = 4'b0100,
		LSU_LHS = 4'b0101, LSU_LWZ = 4'b0110, LSU_LWS = 4'b0111,
		LSU_SB = 4'b1010, LSU_SH = 4'b1100, LSU_SW = 4'b1110
	} lsu_op_e;

	// write-back source, paired with a separate enable
	typedef enum logic [1:0] {
		RFWB_ALU = 2'd0, RFWB_LSU = 2'd1, RFWB_SPRS = 2'd2, RFWB_LR = 2'd3
	} rfwb_src_e;

	// operand source for the alu inputs
	typedef enum logic [1:0] {
		SEL_RF = 2'd0, SEL_IMM = 2'd1, SEL_EX_FORW = 2'd2, SEL_WB_FORW = 2'd3
	} sel_e;

endpackage

/* hw/ctrl_top.sv */
`timescale 1ns/1ps
`include "ctrl_defines.svh"

module ctrl_top import ctrl_pkg::*; (
	input  logic                       clk,
	input  logic                       reset,
	input  logic [`CTRL_INSN_W-1:0]    if_insn,
	input  logic [`CTRL_INSN_W-1:0]    id_pc,
	input  logic                       id_freeze,
	input  logic                       ex_freeze,
	input  logic                       wb_freeze,
	input  logic                       except_flushpipe,
	input  logic                       pc_we,
	input  logic                       extend_flush,
	input  logic                       du_flush_pipe,
	input  logic                       abort_mvspr,
	input  logic                       du_hwbkpt,
	input  logic                       wbforw_valid,
	output logic                       flushpipe,
	output logic [`CTRL_INSN_W-1:0]    id_insn,
	output branch_op_e                 id_branch_op,
	output logic [`CTRL_REG_AW-1:0]    rf_addra,
	output logic [`CTRL_REG_AW-1:0]    rf_addrb,
	output logic                       rf_rda,
	output logic                       rf_rdb,
	output logic [`CTRL_INSN_W-1:0]    id_simm,
	output lsu_op_e                    id_lsu_op,
	output logic [`CTRL_INSN_W-3:0]    id_branch_addrtarget,
	output logic                       multicycle,
	output logic                       id_void,
	output logic [`CTRL_INSN_W-1:0]    ex_insn,
	output logic                       ex_void,
	output logic [`CTRL_INSN_W-1:0]    ex_simm,
	output logic [`CTRL_INSN_W-3:0]    ex_branch_addrtarget,
	output branch_op_e                 ex_branch_op,
	output alu_op_e                    alu_op,
	output logic [`CTRL_ALUOP2_W-1:0]  alu_op2,
	output logic [`CTRL_COMP_W-1:0]    comp_op,
	output rfwb_src_e                  rfwb_op,
	output logic                       rfwb_we,
	output logic [`CTRL_REG_AW-1:0]    rf_addrw,
	output logic                       ex_spr_read,
	output logic                       ex_spr_write,
	output logic                       sig_syscall,
	output logic                       sig_trap,
	output logic                       except_illegal,
	output logic                       rfe,
	output sel_e                       sel_a,
	output sel_e                       sel_b
);

	// registered with id_insn, only forwarding needs it
	logic sel_imm;

	id_stage u_id_stage (
		.clk              (clk),
		.reset            (reset),
		.if_insn          (if_insn),
		.id_freeze        (id_freeze),
		.except_flushpipe (except_flushpipe),
		.pc_we            (pc_we),
		.extend_flush     (extend_flush),
		.du_flush_pipe    (du_flush_pipe),
		.flushpipe        (flushpipe),
		.id_insn          (id_insn),
		.id_branch_op     (id_branch_op),
		.sel_imm          (sel_imm),
		.rf_addra         (rf_addra),
		.rf_addrb         (rf_addrb),
		.rf_rda           (rf_rda),
		.rf_rdb           (rf_rdb)
	);

	id_decode u_id_decode (
		.id_insn              (id_insn),
		.id_pc                (id_pc),
		.id_simm              (id_simm),
		.id_lsu_op            (id_lsu_op),
		.id_branch_addrtarget (id_branch_addrtarget),
		.multicycle           (multicycle),
		.id_void              (id_void)
	);

	ex_stage u_ex_stage (
		.clk                  (clk),
		.reset                (reset),
		.id_freeze            (id_freeze),
		.ex_freeze            (ex_freeze),
		.flushpipe            (flushpipe),
		.abort_mvspr          (abort_mvspr),
		.du_hwbkpt            (du_hwbkpt),
		.id_insn              (id_insn),
		.id_simm              (id_simm),
		.id_branch_addrtarget (id_branch_addrtarget),
		.id_branch_op         (id_branch_op),
		.ex_insn              (ex_insn),
		.ex_void              (ex_void),
		.ex_simm              (ex_simm),
		.ex_branch_addrtarget (ex_branch_addrtarget),
		.ex_branch_op         (ex_branch_op),
		.alu_op               (alu_op),
		.alu_op2              (alu_op2),
		.comp_op              (comp_op),
		.rfwb_op              (rfwb_op),
		.rfwb_we              (rfwb_we),
		.rf_addrw             (rf_addrw),
		.ex_spr_read          (ex_spr_read),
		.ex_spr_write         (ex_spr_write),
		.sig_syscall          (sig_syscall),
		.sig_trap             (sig_trap),
		.except_illegal       (except_illegal),
		.rfe                  (rfe)
	);

	operand_select u_operand_select (
		.clk          (clk),
		.reset        (reset),
		.wb_freeze    (wb_freeze),
		.id_insn      (id_insn),
		.sel_imm      (sel_imm),
		.rf_addrw     (rf_addrw),
		.rfwb_we      (rfwb_we),
		.wbforw_valid (wbforw_valid),
		.sel_a        (sel_a),
		.sel_b        (sel_b)
	);

endmodule

/* hw/ex_stage.sv */
`timescale 1ns/1ps
`include "ctrl_defines.svh"

module ex_stage import ctrl_pkg::*; (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       id_freeze,
	input  logic                       ex_freeze,
	input  logic                       flushpipe,
	input  logic                       abort_mvspr,
	input  logic                       du_hwbkpt,
	input  logic [`CTRL_INSN_W-1:0]    id_insn,
	input  logic [`CTRL_INSN_W-1:0]    id_simm,
	input  logic [`CTRL_INSN_W-3:0]    id_branch_addrtarget,
	input  branch_op_e                 id_branch_op,
	output logic [`CTRL_INSN_W-1:0]    ex_insn,
	output logic                       ex_void,
	output logic [`CTRL_INSN_W-1:0]    ex_simm,
	output logic [`CTRL_INSN_W-3:0]    ex_branch_addrtarget,
	output branch_op_e                 ex_branch_op,
	output alu_op_e                    alu_op,
	output logic [`CTRL_ALUOP2_W-1:0]  alu_op2,
	output logic [`CTRL_COMP_W-1:0]    comp_op,
	output rfwb_src_e                  rfwb_op,
	output logic                       rfwb_we,
	output logic [`CTRL_REG_AW-1:0]    rf_addrw,
	output logic                       ex_spr_read,
	output logic                       ex_spr_write,
	output logic                       sig_syscall,
	output logic                       sig_trap,
	output logic                       except_illegal,
	output logic                       rfe
);

	opcode_e   id_opc;
	logic      bubble;
	alu_op_e   alu_nxt;
	rfwb_src_e wb_src_nxt;
	logic      wb_we_nxt;
	logic      spr_rd_nxt;
	logic      spr_wr_nxt;
	logic      illegal_nxt;
	logic      spr_read;
	logic      spr_write;

	assign id_opc = opcode_e'(id_insn[`CTRL_OPC_MSB:`CTRL_OPC_LSB]);

	// id held while ex moves on leaves an empty slot behind
	assign bubble = (!ex_freeze && id_freeze) || flushpipe;

	//////////////////////////////
	// alu, write-back and spr decode
	//////////////////////////////

	always_comb begin
		alu_nxt     = ALU_NOP;
		wb_src_nxt  = RFWB_ALU;
		wb_we_nxt   = 1'b1;
		spr_rd_nxt  = 1'b0;
		spr_wr_nxt  = 1'b0;
		illegal_nxt = 1'b0;
		case (id_opc)
			OPC_J, OPC_BNF, OPC_BF, OPC_NOP, OPC_XSYNC, OPC_RFE, OPC_JR,
			OPC_SW, OPC_SB, OPC_SH:
				wb_we_nxt = 1'b0;
			OPC_JAL, OPC_JALR:
				wb_src_nxt = RFWB_LR;
			OPC_LWZ, OPC_LWS, OPC_LBZ, OPC_LBS, OPC_LHZ, OPC_LHS:
				wb_src_nxt = RFWB_LSU;
			OPC_MOVHI:   alu_nxt = ALU_MOVHI;
			OPC_ADDI:    alu_nxt = ALU_ADD;
			OPC_ADDIC:   alu_nxt = ALU_ADDC;
			OPC_ANDI:    alu_nxt = ALU_AND;
			OPC_ORI:     alu_nxt = ALU_OR;
			OPC_XORI:    alu_nxt = ALU_XOR;
			OPC_MULI:    alu_nxt = ALU_MUL;
			OPC_SH_ROTI: alu_nxt = ALU_SHROT;
			OPC_MFSPR: begin
				wb_src_nxt = RFWB_SPRS;
				spr_rd_nxt = 1'b1;
			end
			OPC_MTSPR: begin
				wb_we_nxt  = 1'b0;
				spr_wr_nxt = 1'b1;
			end
			// set-flag ops only write the flag
			OPC_SFXX, OPC_SFXXI: begin
				alu_nxt   = ALU_COMP;
				wb_we_nxt = 1'b0;
			end
			OPC_ALU: begin
				alu_nxt     = alu_op_e'({1'b0, id_insn[3:0]});
				// no divider, ffl1 or extension unit here
				illegal_nxt = (alu_nxt == ALU_DIV) || (alu_nxt == ALU_DIVU) ||
				              (alu_nxt == ALU_FFL1) || (alu_nxt == ALU_EXTHB) ||
				              (alu_nxt == ALU_EXTW);
			end
			default: begin
				wb_we_nxt   = 1'b0;
				illegal_nxt = 1'b1;
			end
		endcase
	end

	//////////////////////////////
	// id -> ex control registers
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset || bubble) begin
			ex_insn        <= `CTRL_NOP_INSN;
			ex_branch_op   <= BR_NOP;
			alu_op         <= ALU_NOP;
			alu_op2        <= '0;
			comp_op        <= '0;
			rfwb_op        <= RFWB_ALU;
			rfwb_we        <= 1'b0;
			rf_addrw       <= '0;
			spr_read       <= 1'b0;
			spr_write      <= 1'b0;
			sig_syscall    <= 1'b0;
			sig_trap       <= 1'b0;
			except_illegal <= 1'b0;
		end else if (!ex_freeze) begin
			ex_insn        <= id_insn;
			ex_branch_op   <= id_branch_op;
			alu_op         <= alu_nxt;
			alu_op2        <= id_insn[`CTRL_ALUOP2_MSB:`CTRL_ALUOP2_LSB];
			comp_op        <= id_insn[24:21];
			rfwb_op        <= wb_src_nxt;
			rfwb_we        <= wb_we_nxt;
			// jal and jalr link through r9
			if ((id_opc == OPC_JAL) || (id_opc == OPC_JALR))
				rf_addrw <= `CTRL_LINK_REG;
			else
				rf_addrw <= id_insn[`CTRL_RD_MSB:`CTRL_RD_LSB];
			spr_read       <= spr_rd_nxt;
			spr_write      <= spr_wr_nxt;
			sig_syscall    <= (id_opc == OPC_XSYNC) && (id_insn[25:23] == 3'b000);
			sig_trap       <= ((id_opc == OPC_XSYNC) && (id_insn[25:23] == 3'b010)) || du_hwbkpt;
			except_illegal <= illegal_nxt;
		end
	end

	// operands only follow the pipe
	always_ff @(posedge clk) begin
		if (!ex_freeze) begin
			ex_simm              <= id_simm;
			ex_branch_addrtarget <= id_branch_addrtarget;
		end
	end

	assign ex_void = (ex_insn[`CTRL_OPC_MSB:`CTRL_OPC_LSB] == OPC_NOP) && ex_insn[`CTRL_VOID_BIT];

	// a failed spr move is dropped
	assign ex_spr_read  = spr_read && !abort_mvspr;
	assign ex_spr_write = spr_write && !abort_mvspr;

	assign rfe = (id_branch_op == BR_RFE) || (ex_branch_op == BR_RFE);

endmodule

/* hw/id_decode.sv */
`timescale 1ns/1ps
`include "ctrl_defines.svh"

module id_decode import ctrl_pkg::*; (
	input  logic [`CTRL_INSN_W-1:0]  id_insn,
	input  logic [`CTRL_INSN_W-1:0]  id_pc,
	output logic [`CTRL_INSN_W-1:0]  id_simm,
	output lsu_op_e                  id_lsu_op,
	output logic [`CTRL_INSN_W-3:0]  id_branch_addrtarget,
	output logic                     multicycle,
	output logic                     id_void
);

	opcode_e id_opc;
	logic    imm_sign;
	logic    st_sign;

	assign id_opc   = opcode_e'(id_insn[`CTRL_OPC_MSB:`CTRL_OPC_LSB]);
	assign imm_sign = id_insn[15];
	assign st_sign  = id_insn[25];

	//////////////////////////////
	// immediate extension
	//////////////////////////////

	// stores and mtspr split the offset around the rb field
	always_comb begin
		case (id_opc)
			OPC_ADDI, OPC_ADDIC, OPC_MULI, OPC_XORI, OPC_SFXXI,
			OPC_LWZ, OPC_LWS, OPC_LBZ, OPC_LBS, OPC_LHZ, OPC_LHS:
				id_simm = {{16{imm_sign}}, id_insn[15:0]};
			OPC_MTSPR:
				id_simm = {16'b0, id_insn[25:21], id_insn[10:0]};
			OPC_SW, OPC_SB, OPC_SH:
				id_simm = {{16{st_sign}}, id_insn[25:21], id_insn[10:0]};
			default:
				id_simm = {16'b0, id_insn[15:0]};
		endcase
	end

	//////////////////////////////
	// load/store kind
	//////////////////////////////

	always_comb begin
		case (id_opc)
			OPC_LWZ: id_lsu_op = LSU_LWZ;
			OPC_LWS: id_lsu_op = LSU_LWS;
			OPC_LBZ: id_lsu_op = LSU_LBZ;
			OPC_LBS: id_lsu_op = LSU_LBS;
			OPC_LHZ: id_lsu_op = LSU_LHZ;
			OPC_LHS: id_lsu_op = LSU_LHS;
			OPC_SW:  id_lsu_op = LSU_SW;
			OPC_SB:  id_lsu_op = LSU_SB;
			OPC_SH:  id_lsu_op = LSU_SH;
			default: id_lsu_op = LSU_NOP;
		endcase
	end

	// word-aligned target, offset counts instructions
	assign id_branch_addrtarget = {{4{id_insn[25]}}, id_insn[25:0]} + id_pc[31:2];

	// rfe and mfspr need a second cycle for the spr access
	assign multicycle = (id_opc == OPC_RFE) || (id_opc == OPC_MFSPR);

	assign id_void = (id_opc == OPC_NOP) && id_insn[`CTRL_VOID_BIT];

endmodule

/* hw/id_stage.sv */
`timescale 1ns/1ps
`include "ctrl_defines.svh"

module id_stage import ctrl_pkg::*; (
	input  logic                     clk,
	input  logic                     reset,
	input  logic [`CTRL_INSN_W-1:0]  if_insn,
	input  logic                     id_freeze,
	input  logic                     except_flushpipe,
	input  logic                     pc_we,
	input  logic                     extend_flush,
	input  logic                     du_flush_pipe,
	output logic                     flushpipe,
	output logic [`CTRL_INSN_W-1:0]  id_insn,
	output branch_op_e               id_branch_op,
	output logic                     sel_imm,
	output logic [`CTRL_REG_AW-1:0]  rf_addra,
	output logic [`CTRL_REG_AW-1:0]  rf_addrb,
	output logic                     rf_rda,
	output logic                     rf_rdb
);

	opcode_e    if_opc;
	branch_op_e if_branch_op;
	logic       if_has_imm;

	assign if_opc = opcode_e'(if_insn[`CTRL_OPC_MSB:`CTRL_OPC_LSB]);

	// one flush for the whole pipe
	assign flushpipe = except_flushpipe | pc_we | extend_flush | du_flush_pipe;

	// register file is read straight from the fetched word
	assign rf_addra = if_insn[`CTRL_RA_MSB:`CTRL_RA_LSB];
	assign rf_addrb = if_insn[`CTRL_RB_MSB:`CTRL_RB_LSB];
	assign rf_rda   = if_insn[31];
	assign rf_rdb   = if_insn[30];

	//////////////////////////////
	// branch kind and immediate form
	//////////////////////////////

	always_comb begin
		case (if_opc)
			OPC_J, OPC_JAL:   if_branch_op = BR_J;
			OPC_JR, OPC_JALR: if_branch_op = BR_JR;
			OPC_BNF:          if_branch_op = BR_BNF;
			OPC_BF:           if_branch_op = BR_BF;
			OPC_RFE:          if_branch_op = BR_RFE;
			default:          if_branch_op = BR_NOP;
		endcase
	end

	// register-register forms take operand b from the file
	always_comb begin
		case (if_opc)
			OPC_JALR, OPC_JR, OPC_RFE, OPC_MFSPR, OPC_MTSPR, OPC_XSYNC,
			OPC_SW, OPC_SB, OPC_SH, OPC_ALU, OPC_SFXX, OPC_NOP:
				if_has_imm = 1'b0;
			default:
				if_has_imm = 1'b1;
		endcase
	end

	//////////////////////////////
	// if -> id latch
	//////////////////////////////

	// flush wins over freeze
	always_ff @(posedge clk) begin
		if (reset || flushpipe) begin
			id_insn      <= `CTRL_NOP_INSN;
			id_branch_op <= BR_NOP;
		end else if (!id_freeze) begin
			id_insn      <= if_insn;
			id_branch_op <= if_branch_op;
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			sel_imm <= 1'b0;
		else if (!id_freeze)
			sel_imm <= if_has_imm;
	end

endmodule

/* hw/operand_select.sv */
`timescale 1ns/1ps
`include "ctrl_defines.svh"

module operand_select import ctrl_pkg::*; (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     wb_freeze,
	input  logic [`CTRL_INSN_W-1:0]  id_insn,
	input  logic                     sel_imm,
	input  logic [`CTRL_REG_AW-1:0]  rf_addrw,
	input  logic                     rfwb_we,
	input  logic                     wbforw_valid,
	output sel_e                     sel_a,
	output sel_e                     sel_b
);

	logic [`CTRL_REG_AW-1:0] wb_rfaddrw;

	// ex result beats the older wb result
	function automatic sel_e fwd_sel(input logic [`CTRL_REG_AW-1:0] src);
		sel_e sel;
		if ((src == rf_addrw) && rfwb_we)
			sel = SEL_EX_FORW;
		else if ((src == wb_rfaddrw) && wbforw_valid)
			sel = SEL_WB_FORW;
		else
			sel = SEL_RF;
		return sel;
	endfunction

	// destination one stage behind ex
	always_ff @(posedge clk) begin
		if (reset)
			wb_rfaddrw <= '0;
		else if (!wb_freeze)
			wb_rfaddrw <= rf_addrw;
	end

	//////////////////////////////
	// operand sources
	//////////////////////////////

	assign sel_a = fwd_sel(id_insn[`CTRL_RA_MSB:`CTRL_RA_LSB]);
	assign sel_b = sel_imm ? SEL_IMM : fwd_sel(id_insn[`CTRL_RB_MSB:`CTRL_RB_LSB]);

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -f files.f --top-module ctrl_tb -o ctrl_sim &&
./obj_dir/ctrl_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED" &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* sim/ctrl_tb.sv */
`timescale 1ns/1ps
`include "ctrl_defines.svh"

module ctrl_tb import ctrl_pkg::*; ();

	typedef struct packed {
		logic [31:0] insn;
		logic [31:0] pc;
		// wbforw, hwbkpt, abort, flush, ex_freeze, id_freeze
		logic [5:0]  ctl;
	} row_t;

	logic clk = 1'b0;
	logic reset;
	logic [31:0] if_insn, id_pc;
	logic id_freeze, ex_freeze, wb_freeze;
	logic except_flushpipe, pc_we, extend_flush, du_flush_pipe;
	logic abort_mvspr, du_hwbkpt, wbforw_valid;
	logic flushpipe, rf_rda, rf_rdb, multicycle, id_void, ex_void;
	logic [31:0] id_insn, id_simm, ex_insn, ex_simm;
	logic [29:0] id_branch_addrtarget, ex_branch_addrtarget;
	logic [4:0] rf_addra, rf_addrb, rf_addrw;
	logic [3:0] alu_op2, comp_op;
	logic rfwb_we, ex_spr_read, ex_spr_write, sig_syscall, sig_trap, except_illegal, rfe;
	branch_op_e id_branch_op, ex_branch_op;
	lsu_op_e id_lsu_op;
	alu_op_e alu_op;
	rfwb_src_e rfwb_op;
	sel_e sel_a, sel_b;

	row_t rows[$];
	logic table_ready = 1'b0;
	int n_checks = 0;
	int n_errors = 0;

	// reference state of the pipe
	logic [31:0] m_id_insn, m_ex_insn, m_ex_simm;
	logic [29:0] m_ex_tgt;
	logic [2:0]  m_id_br, m_ex_br;
	logic        m_sel_imm, m_we, m_sprr, m_sprw, m_sys, m_trap, m_ill;
	logic [4:0]  m_alu, m_addrw, m_wb_addrw;
	logic [3:0]  m_alu2, m_comp;
	logic [1:0]  m_src;

	ctrl_top dut_i (.*);

	always #5 clk = ~clk;

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		n_checks++;
		if (exp !== act) begin
			n_errors++;
			$display("MISMATCH t=%0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	function automatic logic [31:0] mk(input logic [5:0] opc, input logic [4:0] rd,
			input logic [4:0] ra, input logic [4:0] rb, input logic [10:0] lo);
		return {opc, rd, ra, rb, lo};
	endfunction

	function automatic logic [2:0] exp_branch(input logic [31:0] w);
		case (w[31:26])
			OPC_J, OPC_JAL:   return BR_J;
			OPC_JR, OPC_JALR: return BR_JR;
			OPC_BF:           return BR_BF;
			OPC_BNF:          return BR_BNF;
			OPC_RFE:          return BR_RFE;
			default:          return BR_NOP;
		endcase
	endfunction

	function automatic logic exp_has_imm(input logic [31:0] w);
		case (w[31:26])
			OPC_JALR, OPC_JR, OPC_RFE, OPC_MFSPR, OPC_MTSPR, OPC_XSYNC,
			OPC_SW, OPC_SB, OPC_SH, OPC_ALU, OPC_SFXX, OPC_NOP: return 1'b0;
			default: return 1'b1;
		endcase
	endfunction

	function automatic logic [31:0] exp_simm(input logic [31:0] w);
		case (w[31:26])
			OPC_ADDI, OPC_ADDIC, OPC_MULI, OPC_XORI, OPC_SFXXI,
			OPC_LWZ, OPC_LWS, OPC_LBZ, OPC_LBS, OPC_LHZ, OPC_LHS:
				return {{16{w[15]}}, w[15:0]};
			OPC_MTSPR:              return {16'b0, w[25:21], w[10:0]};
			OPC_SW, OPC_SB, OPC_SH: return {{16{w[25]}}, w[25:21], w[10:0]};
			default:                return {16'b0, w[15:0]};
		endcase
	endfunction

	// word target wraps inside 30 bits
	function automatic logic [29:0] exp_target(input logic [31:0] w, input logic [31:0] pc);
		return {{4{w[25]}}, w[25:0]} + pc[31:2];
	endfunction

	function automatic logic [3:0] exp_lsu(input logic [31:0] w);
		case (w[31:26])
			OPC_LWZ: return LSU_LWZ;
			OPC_LWS: return LSU_LWS;
			OPC_LBZ: return LSU_LBZ;
			OPC_LBS: return LSU_LBS;
			OPC_LHZ: return LSU_LHZ;
			OPC_LHS: return LSU_LHS;
			OPC_SW:  return LSU_SW;
			OPC_SB:  return LSU_SB;
			OPC_SH:  return LSU_SH;
			default: return LSU_NOP;
		endcase
	endfunction

	function automatic logic [1:0] exp_fwd(input logic [4:0] src, input logic wbf);
		if (src == m_addrw && m_we)
			return SEL_EX_FORW;
		else if (src == m_wb_addrw && wbf)
			return SEL_WB_FORW;
		return SEL_RF;
	endfunction

	task automatic ex_clear();
		m_ex_insn = `CTRL_NOP_INSN;
		m_ex_br = BR_NOP;
		m_alu = ALU_NOP;
		{m_alu2, m_comp, m_addrw} = '0;
		m_src = RFWB_ALU;
		{m_we, m_sprr, m_sprw, m_sys, m_trap, m_ill} = '0;
	endtask

	task automatic ex_load(input logic [31:0] w, input logic hw);
		ex_clear();
		m_ex_insn = w;
		m_ex_br = m_id_br;
		m_alu2 = w[9:6];
		m_comp = w[24:21];
		m_addrw = (w[31:26] == OPC_JAL || w[31:26] == OPC_JALR) ? 5'd9 : w[25:21];
		m_sys = (w[31:26] == OPC_XSYNC) && (w[25:23] == 3'b000);
		m_trap = ((w[31:26] == OPC_XSYNC) && (w[25:23] == 3'b010)) || hw;
		m_we = 1'b1;
		case (w[31:26])
			OPC_J, OPC_BNF, OPC_BF, OPC_NOP, OPC_XSYNC, OPC_RFE, OPC_JR,
			OPC_SW, OPC_SB, OPC_SH: m_we = 1'b0;
			OPC_JAL, OPC_JALR: m_src = RFWB_LR;
			OPC_LWZ, OPC_LWS, OPC_LBZ, OPC_LBS, OPC_LHZ, OPC_LHS: m_src = RFWB_LSU;
			OPC_MOVHI: m_alu = ALU_MOVHI;
			OPC_ADDI: m_alu = ALU_ADD;
			OPC_ADDIC: m_alu = ALU_ADDC;
			OPC_ANDI: m_alu = ALU_AND;
			OPC_ORI: m_alu = ALU_OR;
			OPC_XORI: m_alu = ALU_XOR;
			OPC_MULI: m_alu = ALU_MUL;
			OPC_SH_ROTI: m_alu = ALU_SHROT;
			OPC_MFSPR: begin
				m_src = RFWB_SPRS;
				m_sprr = 1'b1;
			end
			OPC_MTSPR: begin
				m_we = 1'b0;
				m_sprw = 1'b1;
			end
			OPC_SFXX, OPC_SFXXI: begin
				m_alu = ALU_COMP;
				m_we = 1'b0;
			end
			OPC_ALU: begin
				m_alu = {1'b0, w[3:0]};
				m_ill = (w[3:0] inside {4'd9, 4'd10, 4'd12, 4'd13, 4'd15});
			end
			default: begin
				m_we = 1'b0;
				m_ill = 1'b1;
			end
		endcase
	endtask

	// one rising edge of the reference pipe
	task automatic model_step(input row_t r);
		logic bubble;
		bubble = r.ctl[2] || (r.ctl[0] && !r.ctl[1]);
		m_wb_addrw = m_addrw;
		if (!r.ctl[1]) begin
			m_ex_simm = exp_simm(m_id_insn);
			m_ex_tgt = exp_target(m_id_insn, r.pc);
		end
		if (bubble)
			ex_clear();
		else if (!r.ctl[1])
			ex_load(m_id_insn, r.ctl[4]);
		if (!r.ctl[0])
			m_sel_imm = exp_has_imm(r.insn);
		if (r.ctl[2]) begin
			m_id_insn = `CTRL_NOP_INSN;
			m_id_br = BR_NOP;
		end else if (!r.ctl[0]) begin
			m_id_insn = r.insn;
			m_id_br = exp_branch(r.insn);
		end
	endtask

	task automatic check_all(input row_t r);
		logic [31:0] w;
		w = m_id_insn;
		check("flushpipe", 32'(r.ctl[2]), 32'(flushpipe));
		check("rf_addra", 32'(r.insn[20:16]), 32'(rf_addra));
		check("rf_addrb", 32'(r.insn[15:11]), 32'(rf_addrb));
		check("rf_rda", 32'(r.insn[31]), 32'(rf_rda));
		check("rf_rdb", 32'(r.insn[30]), 32'(rf_rdb));
		check("id_insn", w, id_insn);
		check("id_branch_op", 32'(m_id_br), 32'(id_branch_op));
		check("id_lsu_op", 32'(exp_lsu(w)), 32'(id_lsu_op));
		check("id_simm", exp_simm(w), id_simm);
		check("id_branch_addrtarget", 32'(exp_target(w, r.pc)), 32'(id_branch_addrtarget));
		check("multicycle", 32'(w[31:26] == OPC_RFE || w[31:26] == OPC_MFSPR), 32'(multicycle));
		check("id_void", 32'(w[31:26] == OPC_NOP && w[16]), 32'(id_void));
		check("ex_insn", m_ex_insn, ex_insn);
		check("ex_void", 32'(m_ex_insn[31:26] == OPC_NOP && m_ex_insn[16]), 32'(ex_void));
		check("ex_simm", m_ex_simm, ex_simm);
		check("ex_branch_addrtarget", 32'(m_ex_tgt), 32'(ex_branch_addrtarget));
		check("ex_branch_op", 32'(m_ex_br), 32'(ex_branch_op));
		check("alu_op", 32'(m_alu), 32'(alu_op));
		check("alu_op2", 32'(m_alu2), 32'(alu_op2));
		check("comp_op", 32'(m_comp), 32'(comp_op));
		check("rfwb_op", 32'(m_src), 32'(rfwb_op));
		check("rfwb_we", 32'(m_we), 32'(rfwb_we));
		check("rf_addrw", 32'(m_addrw), 32'(rf_addrw));
		check("ex_spr_read", 32'(m_sprr && !r.ctl[3]), 32'(ex_spr_read));
		check("ex_spr_write", 32'(m_sprw && !r.ctl[3]), 32'(ex_spr_write));
		check("sig_syscall", 32'(m_sys), 32'(sig_syscall));
		check("sig_trap", 32'(m_trap), 32'(sig_trap));
		check("except_illegal", 32'(m_ill), 32'(except_illegal));
		check("rfe", 32'(m_id_br == BR_RFE || m_ex_br == BR_RFE), 32'(rfe));
		check("sel_a", 32'(exp_fwd(w[20:16], r.ctl[5])), 32'(sel_a));
		check("sel_b", 32'(m_sel_imm ? 2'(SEL_IMM) : exp_fwd(w[15:11], r.ctl[5])), 32'(sel_b));
	endtask

	task automatic add(input logic [31:0] insn, input logic [5:0] ctl);
		row_t r;
		r.insn = insn;
		r.pc = {30'($urandom), 2'b00};
		r.ctl = ctl;
		rows.push_back(r);
	endtask

	task automatic drive(input row_t r, input int idx);
		if_insn = r.insn;
		id_pc = r.pc;
		id_freeze = r.ctl[0];
		ex_freeze = r.ctl[1];
		{except_flushpipe, pc_we, extend_flush, du_flush_pipe} = '0;
		case (idx % 4)
			0: except_flushpipe = r.ctl[2];
			1: pc_we = r.ctl[2];
			2: extend_flush = r.ctl[2];
			default: du_flush_pipe = r.ctl[2];
		endcase
		abort_mvspr = r.ctl[3];
		du_hwbkpt = r.ctl[4];
		wbforw_valid = r.ctl[5];
	endtask

	//////////////////////////////
	// stimulus table
	//////////////////////////////

	task automatic build_table();
		logic [5:0] opcs[$];
		opcs = '{6'h00, 6'h01, 6'h03, 6'h04, 6'h05, 6'h06, 6'h08, 6'h09, 6'h11, 6'h12,
		         6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h28, 6'h29, 6'h2a,
		         6'h2b, 6'h2c, 6'h2d, 6'h2e, 6'h2f, 6'h30, 6'h35, 6'h36, 6'h37, 6'h38,
		         6'h39};
		foreach (opcs[k])
			add({opcs[k], 26'($urandom)}, 6'b0);
		add(mk(OPC_XSYNC, 5'b00000, 5'd0, 5'd0, 11'd0), 6'b0);
		add(mk(OPC_XSYNC, 5'b01000, 5'd0, 5'd0, 11'd0), 6'b0);
		add(mk(OPC_ADDI, 5'd7, 5'd1, 5'd2, 11'h7ff), 6'b0);
		add(mk(OPC_ORI, 5'd8, 5'd1, 5'd2, 11'h01), 6'b010000);
		add({6'h3f, 26'($urandom)}, 6'b0);
		add(mk(OPC_ALU, 5'd6, 5'd1, 5'd2, 11'd9), 6'b0);
		add(mk(OPC_MFSPR, 5'd5, 5'd1, 5'd2, 11'd3), 6'b0);
		add(mk(OPC_MTSPR, 5'd5, 5'd1, 5'd2, 11'd3), 6'b001000);
		add(mk(OPC_MFSPR, 5'd5, 5'd1, 5'd2, 11'd3), 6'b001000);
		add(mk(OPC_MTSPR, 5'd5, 5'd1, 5'd2, 11'd3), 6'b0);
		add(mk(OPC_ANDI, 5'd10, 5'd1, 5'd2, 11'd3), 6'b0);
		// each flush source in turn, id stall bubble, then an ex hold
		add(mk(OPC_ADDI, 5'd11, 5'd1, 5'd2, 11'd4), 6'b000100);
		add(mk(OPC_ADDI, 5'd11, 5'd1, 5'd2, 11'd4), 6'b000100);
		add(mk(OPC_ADDI, 5'd11, 5'd1, 5'd2, 11'd4), 6'b000100);
		add(mk(OPC_ADDI, 5'd11, 5'd1, 5'd2, 11'd4), 6'b000100);
		add(mk(OPC_ADDI, 5'd12, 5'd1, 5'd2, 11'd5), 6'b0);
		add(mk(OPC_ADDI, 5'd13, 5'd1, 5'd2, 11'd6), 6'b000001);
		add(mk(OPC_ADDI, 5'd13, 5'd1, 5'd2, 11'd6), 6'b000001);
		add(mk(OPC_ADDI, 5'd13, 5'd1, 5'd2, 11'd6), 6'b0);
		add(mk(OPC_ADDI, 5'd14, 5'd1, 5'd2, 11'd7), 6'b000011);
		add(mk(OPC_ADDI, 5'd14, 5'd1, 5'd2, 11'd7), 6'b000011);
		add(mk(OPC_ADDI, 5'd14, 5'd1, 5'd2, 11'd7), 6'b0);
		// forwarding from ex, then from wb
		add(mk(OPC_ADDI, 5'd3, 5'd1, 5'd2, 11'd1), 6'b0);
		add(mk(OPC_ALU, 5'd15, 5'd3, 5'd3, 11'd0), 6'b0);
		add(mk(OPC_ADDI, 5'd4, 5'd1, 5'd2, 11'd1), 6'b0);
		add(mk(OPC_ORI, 5'd16, 5'd1, 5'd2, 11'd1), 6'b0);
		add(mk(OPC_ALU, 5'd17, 5'd4, 5'd4, 11'd0), 6'b100000);
		add(mk(OPC_ADDI, 5'd18, 5'd17, 5'd2, 11'd1), 6'b0);
		add(`CTRL_NOP_INSN, 6'b0);
		add(`CTRL_NOP_INSN, 6'b0);
	endtask

	initial begin
		row_t nop_row;
		void'($urandom(8));
		nop_row.insn = `CTRL_NOP_INSN;
		nop_row.pc = '0;
		nop_row.ctl = '0;
		wb_freeze = 1'b0;
		reset = 1'b1;
		drive(nop_row, 0);
		build_table();
		table_ready = 1'b1;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		m_id_insn = `CTRL_NOP_INSN;
		m_id_br = BR_NOP;
		m_sel_imm = 1'b0;
		m_wb_addrw = '0;
		m_ex_simm = exp_simm(`CTRL_NOP_INSN);
		m_ex_tgt = exp_target(`CTRL_NOP_INSN, nop_row.pc);
		ex_clear();
		check_all(nop_row);
		foreach (rows[i]) begin
			drive(rows[i], i);
			@(posedge clk);
			model_step(rows[i]);
			@(negedge clk);
			check_all(rows[i]);
		end
		$display("checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	// run length plus reset and margin
	initial begin
		wait (table_ready);
		#((rows.size() + 30) * 10);
		$display("watchdog expired before the stimulus table finished");
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule
